// ==== ballEngine.sv ====
`default_nettype none

module ballEngine
(
	input  logic                 DIV_CLK,
	input  logic                 reset,
	input  logic                 frameTick,		// One-cycle game tick
	input  logic                 startButton,
	input  pongPkg::paddlePair_t paddles,
	output pongPkg::ballPos_t    ball,
	output pongPkg::scoreReq_t   scoreReq,
	input  pongPkg::scoreAck_t   scoreAck
);

	pongPkg::rallyState_t state;
	logic                 dirX;				// 1 moves right
	logic                 dirY;				// 1 moves down
	pongPkg::speed_t      speedX;
	pongPkg::speed_t      speedY;
	logic [1:0]           tickCount;		// Ball moves once per four ticks
	logic                 matchOverSeen;	// Captured while ack is high

	pongPkg::xCoord_t stepX;
	pongPkg::yCoord_t stepY;
	pongPkg::xCoord_t ballRightX;
	pongPkg::yCoord_t ballMidY;
	pongPkg::yCoord_t leftPadEndY;
	pongPkg::yCoord_t rightPadEndY;
	logic             leftHit;
	logic             rightHit;
	logic             goalLeft;		// Left player scores
	logic             goalRight;	// Right player scores

	//////////////////////////////////////////////////////////////////////
	// Collision and goal tests on the current ball
	//////////////////////////////////////////////////////////////////////

	assign stepX = pongPkg::xCoord_t'(speedX);
	assign stepY = pongPkg::yCoord_t'(speedY);

	assign ballRightX = ball.x + pongPkg::xCoord_t'(pongPkg::BALL_SIZE);	// Leading edge
	assign ballMidY   = ball.y + pongPkg::yCoord_t'(pongPkg::BALL_SIZE / 2);

	assign leftPadEndY  = paddles.leftY + pongPkg::yCoord_t'(pongPkg::PADDLE_H);
	assign rightPadEndY = paddles.rightY + pongPkg::yCoord_t'(pongPkg::PADDLE_H);

	// Left edge midpoint inside left paddle
	assign leftHit = (ball.x >= pongPkg::LEFT_PADDLE_X)
		&& (ball.x < pongPkg::LEFT_PADDLE_X + pongPkg::xCoord_t'(pongPkg::PADDLE_W))
		&& (ballMidY >= paddles.leftY)
		&& (ballMidY < leftPadEndY);

	// Right edge midpoint inside right paddle
	assign rightHit = (ballRightX >= pongPkg::RIGHT_PADDLE_X)
		&& (ballRightX < pongPkg::RIGHT_PADDLE_X + pongPkg::xCoord_t'(pongPkg::PADDLE_W))
		&& (ballMidY >= paddles.rightY)
		&& (ballMidY < rightPadEndY);

	assign goalRight = ball.x < stepX;	// Next step would pass x = 0
	assign goalLeft  = ball.x >= pongPkg::RIGHT_GOAL_X;

	//////////////////////////////////////////////////////////////////////
	// Rally FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			state         <= pongPkg::S_MENU;
			ball.x        <= pongPkg::SERVE_X;
			ball.y        <= pongPkg::SERVE_Y;
			dirX          <= 1'b1;
			dirY          <= 1'b0;
			speedX        <= pongPkg::START_SPEED;
			speedY        <= pongPkg::START_SPEED;
			tickCount     <= 2'd0;
			scoreReq.req  <= 1'b0;
			scoreReq.op   <= pongPkg::OP_CLEAR;
			matchOverSeen <= 1'b0;
		end
		else
		begin
			case (state)
				pongPkg::S_MENU:
				begin
					if (startButton)
					begin
						// New match starts by wiping both scores
						scoreReq.req <= 1'b1;
						scoreReq.op  <= pongPkg::OP_CLEAR;
						state        <= pongPkg::S_CLEAR;
					end
				end
				pongPkg::S_PLAY:
				begin
					if (frameTick)
					begin
						tickCount <= tickCount + 2'd1;
						if (tickCount == 2'd0)
							state <= pongPkg::S_MOVE;	// 1st, 5th, 9th tick
					end
				end
				pongPkg::S_MOVE:
				begin
					if (dirX)
						ball.x <= ball.x + stepX;
					else
						ball.x <= ball.x - stepX;
					if (dirY)
						ball.y <= ball.y + stepY;
					else
						ball.y <= ball.y - stepY;
					state <= pongPkg::S_CHECK;
				end
				pongPkg::S_CHECK:
				begin
					// Top and bottom walls
					if (ball.y < stepY)
						dirY <= 1'b1;
					else if (ball.y >= pongPkg::BOTTOM_WALL_Y)
						dirY <= 1'b0;

					// Paddle return speeds the ball up on both axes
					if (leftHit || rightHit)
					begin
						dirX   <= leftHit;
						speedX <= speedX + 7'd1;
						speedY <= speedY + 7'd1;
					end

					if (goalRight)
					begin
						scoreReq.req <= 1'b1;
						scoreReq.op  <= pongPkg::OP_POINT_RIGHT;
						state        <= pongPkg::S_GOAL;
					end
					else if (goalLeft)
					begin
						scoreReq.req <= 1'b1;
						scoreReq.op  <= pongPkg::OP_POINT_LEFT;
						state        <= pongPkg::S_GOAL;
					end
					else
						state <= pongPkg::S_PLAY;
				end
				pongPkg::S_CLEAR, pongPkg::S_GOAL:
				begin
					// Wait for the board to perform the operation
					if (scoreAck.ack)
					begin
						matchOverSeen <= scoreAck.matchOver;
						scoreReq.req  <= 1'b0;
						state         <= pongPkg::S_RELEASE;
					end
				end
				pongPkg::S_RELEASE:
				begin
					if (!scoreAck.ack)	// Handshake closed
					begin
						ball.x    <= pongPkg::SERVE_X;
						ball.y    <= pongPkg::SERVE_Y;
						dirY      <= 1'b0;
						tickCount <= 2'd0;
						// Serve toward whoever just conceded
						dirX <= (scoreReq.op != pongPkg::OP_POINT_RIGHT);
						if (scoreReq.op == pongPkg::OP_CLEAR)
						begin
							speedX <= pongPkg::START_SPEED;
							speedY <= pongPkg::START_SPEED;
						end
						else
						begin
							speedX <= pongPkg::SERVE_SPEED;
							speedY <= pongPkg::SERVE_SPEED;
						end
						state <= matchOverSeen ? pongPkg::S_MENU : pongPkg::S_PLAY;
					end
				end
				default:
					state <= pongPkg::S_MENU;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== paddleTracker.sv ====
`default_nettype none

module paddleTracker
(
	input  logic                 DIV_CLK,
	input  logic                 reset,
	input  logic                 frameTick,	// One-cycle game tick
	input  logic [7:0]           knobLeft,
	input  logic [7:0]           knobRight,
	output pongPkg::paddlePair_t paddles
);

	//////////////////////////////////////////////////////////////////////
	// Knob to paddle height
	//////////////////////////////////////////////////////////////////////

	// Double the reading, drop the dead zone, clamp to screen
	function automatic pongPkg::yCoord_t knobToHeight(input logic [7:0] knob);
		logic [8:0]       doubled;
		pongPkg::yCoord_t shifted;
		pongPkg::yCoord_t height;
		doubled = {knob, 1'b0};
		shifted = {1'b0, doubled} - {1'b0, pongPkg::KNOB_DEADZONE};
		if (doubled < pongPkg::KNOB_DEADZONE)
			height = '0;	// Inside dead zone
		else if (shifted > pongPkg::PADDLE_MAX_Y)
			height = pongPkg::PADDLE_MAX_Y;	// Paddle bottom at screen edge
		else
			height = shifted;
		return height;
	endfunction

	pongPkg::yCoord_t leftHeight;
	pongPkg::yCoord_t rightHeight;

	assign leftHeight  = knobToHeight(knobLeft);
	assign rightHeight = knobToHeight(knobRight);

	//////////////////////////////////////////////////////////////////////
	// Sample on each frame tick
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			paddles <= '0;	// Both paddles at the top
		end
		else if (frameTick)
		begin
			// Updated regardless of rally state
			paddles.leftY  <= leftHeight;
			paddles.rightY <= rightHeight;
		end
	end

endmodule

`default_nettype wire

// ==== pongPkg.sv ====
`default_nettype none

package pongPkg;

	//////////////////////////////////////////////////////////////////////
	// Coordinate and score types
	//////////////////////////////////////////////////////////////////////

	typedef logic [10:0] xCoord_t;	// Horizontal pixel position
	typedef logic [9:0]  yCoord_t;	// Vertical pixel position
	typedef logic [6:0]  speed_t;	// Pixels per move tick
	typedef logic [3:0]  score_t;	// One hex digit per player

	// Paddle tops, left first
	typedef struct packed
	{
		yCoord_t leftY;
		yCoord_t rightY;
	} paddlePair_t;

	// Ball top-left corner
	typedef struct packed
	{
		xCoord_t x;
		yCoord_t y;
	} ballPos_t;

	// Operations handed from rally FSM to scoreboard
	typedef enum logic [1:0]
	{
		OP_CLEAR,
		OP_POINT_LEFT,
		OP_POINT_RIGHT
	} scoreOp_t;

	typedef struct packed
	{
		logic     req;	// Four-phase request
		scoreOp_t op;	// Held stable while req is high
	} scoreReq_t;

	typedef struct packed
	{
		logic ack;
		logic matchOver;	// Only meaningful while ack is high
	} scoreAck_t;

	// Rally FSM states
	typedef enum logic [2:0]
	{
		S_MENU,
		S_CLEAR,
		S_PLAY,
		S_MOVE,
		S_CHECK,
		S_GOAL,
		S_RELEASE
	} rallyState_t;

	// Seven-segment drive, all active low
	typedef struct packed
	{
		logic [3:0] anodes;
		logic [6:0] cathodes;	// Segment a in the MSB down to g
	} segDrive_t;

	//////////////////////////////////////////////////////////////////////
	// Geometry and game constants
	//////////////////////////////////////////////////////////////////////

	localparam int SCREEN_W  = 640;
	localparam int SCREEN_H  = 480;
	localparam int BALL_SIZE = 10;
	localparam int PADDLE_W  = 10;
	localparam int PADDLE_H  = 50;

	localparam xCoord_t RIGHT_GOAL_X   = xCoord_t'(SCREEN_W - BALL_SIZE);	// 630
	localparam yCoord_t BOTTOM_WALL_Y  = yCoord_t'(SCREEN_H - BALL_SIZE);	// 470
	localparam xCoord_t LEFT_PADDLE_X  = 11'd40;
	localparam xCoord_t RIGHT_PADDLE_X = 11'd600;

	// Serve point is the screen centre less half a ball
	localparam xCoord_t SERVE_X = xCoord_t'((SCREEN_W - BALL_SIZE) / 2);	// 315
	localparam yCoord_t SERVE_Y = yCoord_t'((SCREEN_H - BALL_SIZE) / 2);	// 235

	localparam speed_t START_SPEED = 7'd2;	// Fresh match
	localparam speed_t SERVE_SPEED = 7'd1;	// After a goal

	localparam logic [8:0] KNOB_DEADZONE = 9'd41;
	localparam yCoord_t    PADDLE_MAX_Y  = yCoord_t'(SCREEN_H - PADDLE_H);	// 430

	localparam int DEFAULT_WIN_SCORE = 11;
	localparam int DEFAULT_SCAN_BITS = 18;	// Roughly 190 Hz digit rate at 50 MHz

endpackage

`default_nettype wire

// ==== pongTb.sv ====
`default_nettype none

module pongTb;

	localparam int MAX_CMDS = 128;
	localparam int TICK_GAP = 16;	// Cycles between frame ticks

	logic                 DIV_CLK;
	logic                 reset;
	logic                 frameTick;
	logic                 startButton;
	logic [7:0]           knobLeft;
	logic [7:0]           knobRight;
	pongPkg::paddlePair_t paddles;
	pongPkg::ballPos_t    ball;
	pongPkg::score_t      leftScore;
	pongPkg::score_t      rightScore;
	pongPkg::segDrive_t   segs;

	// Parsed command table
	logic [63:0] cmdWord [0:MAX_CMDS-1];
	logic [63:0] cmdName [0:MAX_CMDS-1];
	logic [31:0] cmdArgA [0:MAX_CMDS-1];
	logic [31:0] cmdArgB [0:MAX_CMDS-1];
	int          numCmds;
	int          totalTicks;	// Sizes the watchdog
	logic        loaded;

	pongTop #(
		.WIN_SCORE (3),
		.SCAN_BITS (4)
	) i_dut
	(
		.DIV_CLK     (DIV_CLK),
		.reset       (reset),
		.frameTick   (frameTick),
		.startButton (startButton),
		.knobLeft    (knobLeft),
		.knobRight   (knobRight),
		.paddles     (paddles),
		.ball        (ball),
		.leftScore   (leftScore),
		.rightScore  (rightScore),
		.segs        (segs)
	);

	//////////////////////////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////////////////////////

	task automatic failRun(input string reason);
		$display("%0s", reason);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			failRun($sformatf("error: %0s is %0h, expected %0h", name, actual, expected));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus file
	//////////////////////////////////////////////////////////////////////

	task automatic loadTests();
		int           fd;
		int           count;
		logic [639:0] lineBuf;
		logic [63:0]  word;
		logic [63:0]  name;
		logic [31:0]  argA;
		logic [31:0]  argB;
		fd = $fopen("pongTests.txt", "r");
		if (fd == 0)
			failRun("error: cannot open pongTests.txt");
		else
		begin
			while (!$feof(fd))
			begin
				lineBuf = '0;
				word    = '0;
				name    = '0;
				argA    = '0;
				argB    = '0;
				count   = $fgets(lineBuf, fd);
				count   = $sscanf(lineBuf, "%s", word);
				if (count >= 1 && word != "#")	// Skip blanks and comments
				begin
					case (word)
						"expect": count = $sscanf(lineBuf, "%s %s %h", word, name, argA);
						"knob":   count = $sscanf(lineBuf, "%s %h %h", word, argA, argB);
						"tick":   count = $sscanf(lineBuf, "%s %h", word, argA);
						"start":  count = 1;
						default:  failRun("error: unknown command in pongTests.txt");
					endcase
					if (word == "tick")
						totalTicks += argA;
					if (numCmds >= MAX_CMDS)
						failRun("error: too many commands in pongTests.txt");
					cmdWord[numCmds] = word;
					cmdName[numCmds] = name;
					cmdArgA[numCmds] = argA;
					cmdArgB[numCmds] = argB;
					numCmds++;
				end
			end
			$fclose(fd);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Drivers and output checks
	//////////////////////////////////////////////////////////////////////

	task automatic sendTicks(input int count);
		repeat (count)
		begin
			@(posedge DIV_CLK);
			frameTick <= 1'b1;	// One-cycle pulse
			@(posedge DIV_CLK);
			frameTick <= 1'b0;
			repeat (TICK_GAP - 2) @(posedge DIV_CLK);
		end
	endtask

	task automatic pressStart();
		@(posedge DIV_CLK);
		startButton <= 1'b1;
		@(posedge DIV_CLK);
		startButton <= 1'b0;
		repeat (TICK_GAP) @(posedge DIV_CLK);	// Clear handshake settles
	endtask

	// Waits for one digit of the scan, then checks its glyph
	task automatic checkDigit(input logic [3:0] anodeMask, input string name,
		input logic [31:0] expected);
		int waited;
		waited = 0;
		while (segs.anodes != anodeMask && waited < 64)
		begin
			@(negedge DIV_CLK);
			waited++;
		end
		if (segs.anodes != anodeMask)
			failRun("error: the display never selected the expected digit");
		else
			checkValue(name, segs.cathodes, expected);
	endtask

	task automatic expectOutput(input logic [63:0] name, input logic [31:0] expected);
		@(negedge DIV_CLK);	// Outputs stable away from the rising edge
		case (name)
			"padL":  checkValue("paddles.leftY", paddles.leftY, expected);
			"padR":  checkValue("paddles.rightY", paddles.rightY, expected);
			"ballX": checkValue("ball.x", ball.x, expected);
			"ballY": checkValue("ball.y", ball.y, expected);
			"left":  checkValue("leftScore", leftScore, expected);
			"right": checkValue("rightScore", rightScore, expected);
			"dispL": checkDigit(4'b1011, "segs.cathodes left digit", expected);
			"dispR": checkDigit(4'b1110, "segs.cathodes right digit", expected);
			default: failRun("error: unknown output name in pongTests.txt");
		endcase
	endtask

	task automatic runCommand(input int idx);
		case (cmdWord[idx])
			"knob":
			begin
				@(posedge DIV_CLK);
				knobLeft  <= cmdArgA[idx][7:0];
				knobRight <= cmdArgB[idx][7:0];
			end
			"tick":  sendTicks(cmdArgA[idx]);
			"start": pressStart();
			default: expectOutput(cmdName[idx], cmdArgA[idx]);
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Clock, watchdog, main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		DIV_CLK = 1'b0;
		forever #50 DIV_CLK = ~DIV_CLK;
	end

	initial
	begin
		wait (loaded);
		// Every tick gets 20 cycles, plus slack per command
		repeat (totalTicks * 20 + numCmds * 100 + 500) @(posedge DIV_CLK);
		failRun("error: timeout, the tests did not finish in time");
	end

	initial
	begin
		reset       = 1'b1;
		frameTick   = 1'b0;
		startButton = 1'b0;
		knobLeft    = 8'd0;
		knobRight   = 8'd0;
		numCmds     = 0;
		totalTicks  = 0;
		loaded      = 1'b0;
		loadTests();
		loaded = 1'b1;
		repeat (3) @(posedge DIV_CLK);
		reset <= 1'b0;
		@(negedge DIV_CLK);	// First cycle out of reset, all digits dark
		checkValue("segs.anodes", segs.anodes, 32'hf);
		for (int i = 0; i < numCmds; i++)
			runCommand(i);
		@(negedge DIV_CLK);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pongTests.txt ====
# Columns: command then hex arguments
# knob <left> <right> | tick <count> | start | expect <output> <value>
# Knob rule, game still in the menu
knob 00 00
tick 1
expect padL 0
expect padR 0
knob 14 15
tick 1
expect padL 0
expect padR 1
knob 78 ff
tick 1
expect padL c7
expect padR 1ae
expect ballX 13b
expect ballY eb
# Match start, first move tick then three idle ticks
start
expect left 0
expect right 0
expect dispR 01
tick 1
expect ballX 13d
expect ballY e9
tick 3
expect ballX 13d
expect ballY e9
# Climb to the top wall, then fall
tick 1d0
expect ballX 225
expect ballY 1
tick 4
expect ballY 3
tick 4
expect ballY 5
# Right paddle meets the ball, step grows to 3
knob 78 1f
tick 4c
expect padR 15
expect ballX 24f
expect ballY 2b
tick 4
expect ballX 24c
expect ballY 2e
# Left paddle returns the ball
knob be 1f
tick 2d0
expect ballX 30
expect ballY 166
tick 4
expect ballX 34
expect ballY 162
# Right paddle misses, goals for the left player
tick 241
expect left 1
expect ballX 13b
expect ballY eb
expect dispL 4f
knob be ff
tick 4e9
expect left 2
expect dispL 12
tick 4e9
expect left 3
expect right 0
expect dispL 06
expect dispR 01
# Menu ignores the ball, paddles still follow
knob 15 78
tick 4
expect padL 1
expect padR c7
expect ballX 13b
expect ballY eb
start
expect left 0
expect right 0
expect dispL 01

// ==== pongTop.sv ====
`default_nettype none

module pongTop
#(
	parameter int WIN_SCORE = pongPkg::DEFAULT_WIN_SCORE,
	parameter int SCAN_BITS = pongPkg::DEFAULT_SCAN_BITS
)
(
	input  logic                 DIV_CLK,
	input  logic                 reset,
	input  logic                 frameTick,		// Slow game tick
	input  logic                 startButton,
	input  logic [7:0]           knobLeft,
	input  logic [7:0]           knobRight,
	output pongPkg::paddlePair_t paddles,
	output pongPkg::ballPos_t    ball,
	output pongPkg::score_t      leftScore,
	output pongPkg::score_t      rightScore,
	output pongPkg::segDrive_t   segs
);

	// Rally FSM to scoreboard handshake
	pongPkg::scoreReq_t scoreReq;
	pongPkg::scoreAck_t scoreAck;

	//////////////////////////////////////////////////////////////////////
	// Paddles, ball, score
	//////////////////////////////////////////////////////////////////////

	paddleTracker i_paddleTracker
	(
		.DIV_CLK   (DIV_CLK),
		.reset     (reset),
		.frameTick (frameTick),
		.knobLeft  (knobLeft),
		.knobRight (knobRight),
		.paddles   (paddles)
	);

	ballEngine i_ballEngine
	(
		.DIV_CLK     (DIV_CLK),
		.reset       (reset),
		.frameTick   (frameTick),
		.startButton (startButton),
		.paddles     (paddles),
		.ball        (ball),
		.scoreReq    (scoreReq),
		.scoreAck    (scoreAck)
	);

	scoreBoard #(
		.WIN_SCORE (WIN_SCORE),
		.SCAN_BITS (SCAN_BITS)
	) i_scoreBoard
	(
		.DIV_CLK    (DIV_CLK),
		.reset      (reset),
		.scoreReq   (scoreReq),
		.scoreAck   (scoreAck),
		.leftScore  (leftScore),
		.rightScore (rightScore),
		.segs       (segs)
	);

endmodule

`default_nettype wire

// ==== scoreBoard.sv ====
`default_nettype none

module scoreBoard
#(
	parameter int WIN_SCORE = pongPkg::DEFAULT_WIN_SCORE,
	parameter int SCAN_BITS = pongPkg::DEFAULT_SCAN_BITS
)
(
	input  logic               DIV_CLK,
	input  logic               reset,
	input  pongPkg::scoreReq_t scoreReq,
	output pongPkg::scoreAck_t scoreAck,
	output pongPkg::score_t    leftScore,
	output pongPkg::score_t    rightScore,
	output pongPkg::segDrive_t segs
);

	pongPkg::score_t      nextLeft;
	pongPkg::score_t      nextRight;
	logic [SCAN_BITS-1:0] scanCount;
	logic                 scanLive;		// Low only in the first cycle after reset
	logic [1:0]           digitSel;
	pongPkg::score_t      digitValue;

	assign nextLeft  = leftScore + 4'd1;
	assign nextRight = rightScore + 4'd1;

	//////////////////////////////////////////////////////////////////////
	// Score operations, ack side of the handshake
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			scoreAck   <= '0;
			leftScore  <= '0;
			rightScore <= '0;
		end
		else if (scoreReq.req && !scoreAck.ack)
		begin
			scoreAck.ack <= 1'b1;	// Op done in the same cycle
			case (scoreReq.op)
				pongPkg::OP_POINT_LEFT:
				begin
					leftScore          <= nextLeft;
					scoreAck.matchOver <= (nextLeft == pongPkg::score_t'(WIN_SCORE));
				end
				pongPkg::OP_POINT_RIGHT:
				begin
					rightScore         <= nextRight;
					scoreAck.matchOver <= (nextRight == pongPkg::score_t'(WIN_SCORE));
				end
				default:
				begin
					// Clear for a fresh match
					leftScore          <= '0;
					rightScore         <= '0;
					scoreAck.matchOver <= 1'b0;
				end
			endcase
		end
		else if (!scoreReq.req && scoreAck.ack)
		begin
			scoreAck <= '0;	// Req withdrawn, close out
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Digit scan and segment decode
	//////////////////////////////////////////////////////////////////////

	// Standard hex glyphs, segment a first, active low
	function automatic logic [6:0] hexToSeg(input pongPkg::score_t value);
		logic [6:0] seg;
		case (value)
			4'h0:    seg = 7'b0000001;
			4'h1:    seg = 7'b1001111;
			4'h2:    seg = 7'b0010010;
			4'h3:    seg = 7'b0000110;
			4'h4:    seg = 7'b1001100;
			4'h5:    seg = 7'b0100100;
			4'h6:    seg = 7'b0100000;
			4'h7:    seg = 7'b0001111;
			4'h8:    seg = 7'b0000000;
			4'h9:    seg = 7'b0000100;
			4'hA:    seg = 7'b0001000;
			4'hB:    seg = 7'b1100000;	// Lower case b
			4'hC:    seg = 7'b0110001;
			4'hD:    seg = 7'b1000010;	// Lower case d
			4'hE:    seg = 7'b0110000;
			default: seg = 7'b0111000;	// F
		endcase
		return seg;
	endfunction

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			scanCount <= '0;
			scanLive  <= 1'b0;
		end
		else
		begin
			scanCount <= scanCount + SCAN_BITS'(1);
			scanLive  <= 1'b1;
		end
	end

	assign digitSel = scanCount[SCAN_BITS-1 -: 2];	// Top two bits pick the digit

	always_comb
	begin
		case (digitSel)
			2'd0:    digitValue = rightScore;	// Rightmost digit
			2'd2:    digitValue = leftScore;
			default: digitValue = '0;			// Spacer digits
		endcase
		segs.cathodes = hexToSeg(digitValue);
		if (scanLive)
			segs.anodes = ~(4'b0001 << digitSel);
		else
			segs.anodes = 4'b1111;	// Blank
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
pongPkg.sv
paddleTracker.sv
ballEngine.sv
scoreBoard.sv
pongTop.sv
pongTb.sv
